//--- compile.f
source/tmu_geom_pkg.sv
source/tmu_bus_pkg.sv
source/tmu_ifaces.sv
source/tmu_mesh_walker.sv
source/tmu_fetch_vertex.sv
source/tmu_vertex_mem.sv
source/tmu_square_setup.sv
source/tmu_vertex_top.sv
testbench/tmu_vertex_tb.sv

//--- Makefile
# Verilator build and run for the vertex front end testbench.

VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tmu_vertex_tb
FILELIST = compile.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tmu_vertex_tb.sv
// testbench for the vertex front end. loads meshes through the memory
// load port, runs the fetch and setup path and checks every square
// against a model built from the mesh addressing rule.
`timescale 1ns/1ps
`default_nettype none

module tmu_vertex_tb import tmu_geom_pkg::*, tmu_bus_pkg::*; ();

	localparam int MEM_AW = 12;
	localparam int MEM_WORDS = 2 ** MEM_AW;
	localparam int RST_CYCLES = 10;
	localparam int TOTAL_SQUARES = 21;
	localparam int SQUARE_CYCLES = 40;
	localparam int MARGIN_CYCLES = 1000;
	localparam int WATCHDOG_CYCLES = RST_CYCLES + TOTAL_SQUARES * SQUARE_CYCLES + MARGIN_CYCLES;

	typedef struct packed {
		coord_t abx;
		coord_t aby;
		coord_t acx;
		coord_t acy;
		coord_t ax;
		coord_t ay;
		pix_t drx;
		pix_t dry;
	} out_sq_t;

	logic sys_clk;
	logic sys_rst;
	logic mem_we_i;
	logic [MEM_AW-1:0] mem_waddr_i;
	logic [BUS_DW-1:0] mem_wdata_i;
	logic start_i;
	logic busy_o;
	pair_adr_t vertex_adr_i;
	mesh_idx_t vertex_hlast_i;
	mesh_idx_t vertex_vlast_i;
	pix_t dst_hoffset_i;
	pix_t dst_voffset_i;
	sqsize_t dst_squarew_i;
	sqsize_t dst_squareh_i;
	logic sq_stb_o;
	logic sq_ack_i;
	coord_t edge_abx_o;
	coord_t edge_aby_o;
	coord_t edge_acx_o;
	coord_t edge_acy_o;
	coord_t corner_ax_o;
	coord_t corner_ay_o;
	pix_t drx_o;
	pix_t dry_o;

	// copy of every word written through the load port.
	logic [BUS_DW-1:0] image [MEM_WORDS];
	out_sq_t got_q[$];
	out_sq_t held_sq;
	logic stall_seen;
	logic stall_en;
	int stall_run;
	int seed;
	int errors;
	int tests_passed;
	int tests_failed;

	tmu_vertex_top #(
		.MEM_AW(MEM_AW)
	) i_tmu_vertex_top (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.mem_we_i(mem_we_i),
		.mem_waddr_i(mem_waddr_i),
		.mem_wdata_i(mem_wdata_i),
		.start_i(start_i),
		.busy_o(busy_o),
		.vertex_adr_i(vertex_adr_i),
		.vertex_hlast_i(vertex_hlast_i),
		.vertex_vlast_i(vertex_vlast_i),
		.dst_hoffset_i(dst_hoffset_i),
		.dst_voffset_i(dst_voffset_i),
		.dst_squarew_i(dst_squarew_i),
		.dst_squareh_i(dst_squareh_i),
		.sq_stb_o(sq_stb_o),
		.sq_ack_i(sq_ack_i),
		.edge_abx_o(edge_abx_o),
		.edge_aby_o(edge_aby_o),
		.edge_acx_o(edge_acx_o),
		.edge_acy_o(edge_acy_o),
		.corner_ax_o(corner_ax_o),
		.corner_ay_o(corner_ay_o),
		.drx_o(drx_o),
		.dry_o(dry_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// x at word pair*2, y at the word after it, low 18 bits only.
	function automatic coord_t mesh_coord(input pair_adr_t pair, input bit y_word);
		int word;
		word = (int'(pair) * 2 + int'(y_word)) % MEM_WORDS;
		return coord_t'(image[word][COORD_W-1:0]);
	endfunction

	function automatic out_sq_t model_square(input pair_adr_t base, input int i, input int j,
			input pix_t hoff, input pix_t voff, input sqsize_t w, input sqsize_t h);
		out_sq_t r;
		pair_adr_t pa;
		pair_adr_t pb;
		pair_adr_t pc;
		pa = base + pair_adr_t'(j * 128 + i);
		pb = pa + 29'd1;
		pc = pa + 29'd128;
		r.ax = mesh_coord(pa, 1'b0);
		r.ay = mesh_coord(pa, 1'b1);
		r.abx = mesh_coord(pb, 1'b0) - r.ax;
		r.aby = mesh_coord(pb, 1'b1) - r.ay;
		r.acx = mesh_coord(pc, 1'b0) - r.ax;
		r.acy = mesh_coord(pc, 1'b1) - r.ay;
		r.drx = pix_t'(int'(hoff) + i * int'(w));
		r.dry = pix_t'(int'(voff) + j * int'(h));
		return r;
	endfunction

	function automatic out_sq_t current_output();
		out_sq_t r;
		r.abx = edge_abx_o;
		r.aby = edge_aby_o;
		r.acx = edge_acx_o;
		r.acy = edge_acy_o;
		r.ax = corner_ax_o;
		r.ay = corner_ay_o;
		r.drx = drx_o;
		r.dry = dry_o;
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output monitor and downstream ack.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic flag_mismatch(input string msg);
		$display("CHECK FAILED @ %0t: %s", $time, msg);
		errors++;
	endtask

	initial begin : output_monitor
		stall_seen = 1'b0;
		forever begin
			@(posedge sys_clk);
			if (!sys_rst) begin
				// a stalled square must stay put.
				if (stall_seen && (!sq_stb_o || current_output() !== held_sq))
					flag_mismatch("output changed while stalled");
				stall_seen = sq_stb_o && !sq_ack_i;
				held_sq = current_output();
				if (sq_stb_o && sq_ack_i)
					got_q.push_back(current_output());
			end
		end
	end

	// random stretches of ack low or high.
	initial begin : ack_driver
		forever begin
			@(posedge sys_clk);
			if (!stall_en) begin
				sq_ack_i <= 1'b1;
				stall_run = 0;
			end else if (stall_run > 0) begin
				stall_run--;
			end else begin
				sq_ack_i <= ($random(seed) % 2) == 0;
				stall_run = $random(seed) & 7;
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic write_word(input int addr, input logic [BUS_DW-1:0] data);
		@(posedge sys_clk);
		mem_we_i <= 1'b1;
		mem_waddr_i <= MEM_AW'(addr);
		mem_wdata_i <= data;
		image[addr] = data;
		@(posedge sys_clk);
		mem_we_i <= 1'b0;
	endtask

	task automatic load_point(input pair_adr_t base, input int col, input int row,
			input logic [BUS_DW-1:0] x, input logic [BUS_DW-1:0] y);
		int word;
		word = ((int'(base) + row * 128 + col) * 2) % MEM_WORDS;
		write_word(word, x);
		write_word(word + 1, y);
	endtask

	// upper bits are random too and must be ignored.
	task automatic load_random_mesh(input pair_adr_t base, input int hl, input int vl);
		for (int row = 0; row <= vl; row++) begin
			for (int col = 0; col <= hl; col++)
				load_point(base, col, row, $random(seed), $random(seed));
		end
	endtask

	task automatic wait_busy(input logic level);
		while (busy_o !== level)
			@(posedge sys_clk);
	endtask

	task automatic run_mesh(input pair_adr_t base, input mesh_idx_t hl, input mesh_idx_t vl,
			input pix_t hoff, input pix_t voff, input sqsize_t w, input sqsize_t h,
			input bit poke_start);
		out_sq_t exp_sq;
		int n_exp;
		int k;
		n_exp = int'(hl) * int'(vl);
		got_q.delete();
		@(posedge sys_clk);
		vertex_adr_i <= base;
		vertex_hlast_i <= hl;
		vertex_vlast_i <= vl;
		dst_hoffset_i <= hoff;
		dst_voffset_i <= voff;
		dst_squarew_i <= w;
		dst_squareh_i <= h;
		start_i <= 1'b1;
		@(posedge sys_clk);
		start_i <= 1'b0;
		wait_busy(1'b1);
		if (poke_start) begin
			repeat (6) @(posedge sys_clk);
			start_i <= 1'b1;
			@(posedge sys_clk);
			start_i <= 1'b0;
		end
		wait_busy(1'b0);
		while (sq_stb_o)
			@(posedge sys_clk);
		// nothing more may start on its own.
		repeat (8) begin
			@(posedge sys_clk);
			if (busy_o || sq_stb_o)
				flag_mismatch("activity after the run ended");
		end
		if (got_q.size() != n_exp)
			flag_mismatch($sformatf("got %0d squares, expected %0d", got_q.size(), n_exp));
		k = 0;
		for (int j = 0; j < int'(vl); j++) begin
			for (int i = 0; i < int'(hl); i++) begin
				exp_sq = model_square(base, i, j, hoff, voff, w, h);
				if (k < got_q.size() && got_q[k] !== exp_sq)
					flag_mismatch($sformatf("square (%0d,%0d) got %h, expected %h",
						i, j, got_q[k], exp_sq));
				k++;
			end
		end
	endtask

	task automatic close_test(input string name, input int err_at_start);
		if (errors == err_at_start) begin
			$display("test %s: done, no errors", name);
			tests_passed++;
		end else begin
			$display("test %s: done, %0d errors", name, errors - err_at_start);
			tests_failed++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_idle_after_reset();
		int err_at;
		err_at = errors;
		got_q.delete();
		@(posedge sys_clk);
		if (busy_o !== 1'b0 || sq_stb_o !== 1'b0)
			flag_mismatch("busy_o or sq_stb_o high after reset");
		repeat (20) @(posedge sys_clk);
		if (got_q.size() != 0 || busy_o !== 1'b0)
			flag_mismatch("activity without start_i");
		close_test("idle_after_reset", err_at);
	endtask

	task automatic test_single_square();
		int err_at;
		err_at = errors;
		// extreme values, AB y wraps around 18 bits.
		load_point(29'd10, 0, 0, 32'hFFFF_FFFB, 32'h0001_FFFF);
		load_point(29'd10, 1, 0, 32'h1234_0064, 32'h0002_0000);
		load_point(29'd10, 0, 1, 32'hABCE_0000, 32'h0003_FF00);
		load_point(29'd10, 1, 1, 32'h0000_0007, 32'hFFFF_FFF0);
		run_mesh(29'd10, 7'd1, 7'd1, -12'sd3, 12'sd7, 11'd16, 11'd16, 1'b0);
		close_test("single_square", err_at);
	endtask

	task automatic test_random_mesh();
		int err_at;
		err_at = errors;
		load_random_mesh(29'd40, 3, 2);
		run_mesh(29'd40, 7'd3, 7'd2, 12'sd20, -12'sd40, 11'd32, 11'd24, 1'b0);
		close_test("random_mesh", err_at);
	endtask

	task automatic test_stalled_mesh();
		int err_at;
		err_at = errors;
		stall_en = 1'b1;
		run_mesh(29'd40, 7'd3, 7'd2, 12'sd20, -12'sd40, 11'd32, 11'd24, 1'b0);
		stall_en = 1'b0;
		close_test("stalled_mesh", err_at);
	endtask

	task automatic test_restart();
		int err_at;
		err_at = errors;
		load_random_mesh(29'd500, 2, 2);
		load_random_mesh(29'd900, 2, 2);
		run_mesh(29'd500, 7'd2, 7'd2, 12'sd0, 12'sd0, 11'd8, 11'd8, 1'b1);
		run_mesh(29'd900, 7'd2, 7'd2, 12'sd100, 12'sd50, 11'd10, 11'd12, 1'b0);
		close_test("restart", err_at);
	endtask

	initial begin : main_sequence
		seed = 7;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		stall_en = 1'b0;
		stall_run = 0;
		sys_rst = 1'b1;
		mem_we_i = 1'b0;
		mem_waddr_i = '0;
		mem_wdata_i = '0;
		start_i = 1'b0;
		vertex_adr_i = '0;
		vertex_hlast_i = '0;
		vertex_vlast_i = '0;
		dst_hoffset_i = '0;
		dst_voffset_i = '0;
		dst_squarew_i = '0;
		dst_squareh_i = '0;
		sq_ack_i = 1'b1;
		repeat (RST_CYCLES) @(posedge sys_clk);
		sys_rst <= 1'b0;
		test_idle_after_reset();
		test_single_square();
		test_random_mesh();
		test_stalled_mesh();
		test_restart();
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/tmu_vertex_top.sv
// vertex front end top level. vertex memory, fetch block and square
// setup joined by the vertex bus and the square hand-off.
`timescale 1ns/1ps
`default_nettype none

module tmu_vertex_top import tmu_geom_pkg::*, tmu_bus_pkg::*; #(
	parameter int MEM_AW = 12
) (
	input logic sys_clk,
	input logic sys_rst,
	// mesh load port.
	input logic mem_we_i,
	input logic [MEM_AW-1:0] mem_waddr_i,
	input logic [BUS_DW-1:0] mem_wdata_i,
	input logic start_i,
	output logic busy_o,
	input pair_adr_t vertex_adr_i,
	input mesh_idx_t vertex_hlast_i,
	input mesh_idx_t vertex_vlast_i,
	input pix_t dst_hoffset_i,
	input pix_t dst_voffset_i,
	input sqsize_t dst_squarew_i,
	input sqsize_t dst_squareh_i,
	// downstream square output.
	output logic sq_stb_o,
	input logic sq_ack_i,
	output coord_t edge_abx_o,
	output coord_t edge_aby_o,
	output coord_t edge_acx_o,
	output coord_t edge_acy_o,
	output coord_t corner_ax_o,
	output coord_t corner_ay_o,
	output pix_t drx_o,
	output pix_t dry_o
);

	tmu_vb_if vb ();
	tmu_square_if sq ();

	tmu_vertex_mem #(
		.MEM_AW(MEM_AW)
	) i_vertex_mem (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.vb(vb.slave),
		.we_i(mem_we_i),
		.waddr_i(mem_waddr_i),
		.wdata_i(mem_wdata_i)
	);

	tmu_fetch_vertex i_fetch_vertex (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start_i(start_i),
		.busy_o(busy_o),
		.vertex_adr_i(vertex_adr_i),
		.vertex_hlast_i(vertex_hlast_i),
		.vertex_vlast_i(vertex_vlast_i),
		.dst_hoffset_i(dst_hoffset_i),
		.dst_voffset_i(dst_voffset_i),
		.dst_squarew_i(dst_squarew_i),
		.dst_squareh_i(dst_squareh_i),
		.vb(vb.master),
		.sq(sq.source)
	);

	tmu_square_setup i_square_setup (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.sq(sq.sink),
		.out_stb_o(sq_stb_o),
		.out_ack_i(sq_ack_i),
		.edge_abx_o(edge_abx_o),
		.edge_aby_o(edge_aby_o),
		.edge_acx_o(edge_acx_o),
		.edge_acy_o(edge_acy_o),
		.corner_ax_o(corner_ax_o),
		.corner_ay_o(corner_ay_o),
		.drx_o(drx_o),
		.dry_o(dry_o)
	);

endmodule

`default_nettype wire

//--- source/tmu_square_setup.sv
// square setup stage. one output register holding the edge vectors
// AB and AC, corner A and the destination corner of a square.
`timescale 1ns/1ps
`default_nettype none

module tmu_square_setup import tmu_geom_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	tmu_square_if.sink sq,
	output logic out_stb_o,
	input logic out_ack_i,
	output coord_t edge_abx_o,
	output coord_t edge_aby_o,
	output coord_t edge_acx_o,
	output coord_t edge_acy_o,
	output coord_t corner_ax_o,
	output coord_t corner_ay_o,
	output pix_t drx_o,
	output pix_t dry_o
);

	// take a new square when empty or being emptied.
	assign sq.ack = !out_stb_o || out_ack_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			out_stb_o <= 1'b0;
		else if (sq.stb && sq.ack)
			out_stb_o <= 1'b1;
		else if (out_ack_i)
			out_stb_o <= 1'b0;
	end

	// differences wrap to 18 bits.
	always_ff @(posedge sys_clk) begin
		if (sq.stb && sq.ack) begin
			edge_abx_o <= sq.corners.b.x - sq.corners.a.x;
			edge_aby_o <= sq.corners.b.y - sq.corners.a.y;
			edge_acx_o <= sq.corners.c.x - sq.corners.a.x;
			edge_acy_o <= sq.corners.c.y - sq.corners.a.y;
			corner_ax_o <= sq.corners.a.x;
			corner_ay_o <= sq.corners.a.y;
			drx_o <= sq.drx;
			dry_o <= sq.dry;
		end
	end

	a_out_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(out_stb_o && !out_ack_i) |=> (out_stb_o && $stable({edge_abx_o, edge_aby_o,
			edge_acx_o, edge_acy_o, corner_ax_o, corner_ay_o, drx_o, dry_o})));

endmodule

`default_nettype wire

//--- source/tmu_vertex_mem.sv
// on-chip vertex memory. a plain write port loads the mesh,
// reads are served as a vertex bus slave with a one-cycle ack.
`timescale 1ns/1ps
`default_nettype none

module tmu_vertex_mem import tmu_bus_pkg::*; #(
	parameter int MEM_AW = 12
) (
	input logic sys_clk,
	input logic sys_rst,
	tmu_vb_if.slave vb,
	input logic we_i,
	input logic [MEM_AW-1:0] waddr_i,
	input logic [BUS_DW-1:0] wdata_i
);

	logic [BUS_DW-1:0] mem [2**MEM_AW];

	always_ff @(posedge sys_clk) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
		// data lands together with ack.
		if (vb.stb)
			vb.dat_r <= mem[vb.adr[MEM_AW+1:2]];
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			vb.ack <= 1'b0;
		else
			vb.ack <= vb.cyc && vb.stb && !vb.ack;
	end

	a_ack_after_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
		vb.ack |-> $past(vb.stb));

endmodule

`default_nettype wire

//--- source/tmu_fetch_vertex.sv
// vertex fetch block. walks the mesh square by square, reads the corners
// A, C, B, D over the vertex bus and offers each square to setup.
// moving right along a row reuses B and D as the next A and C.
`timescale 1ns/1ps
`default_nettype none

module tmu_fetch_vertex import tmu_geom_pkg::*, tmu_bus_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic start_i,
	output logic busy_o,
	input pair_adr_t vertex_adr_i,
	input mesh_idx_t vertex_hlast_i,
	input mesh_idx_t vertex_vlast_i,
	input pix_t dst_hoffset_i,
	input pix_t dst_voffset_i,
	input sqsize_t dst_squarew_i,
	input sqsize_t dst_squareh_i,
	tmu_vb_if.master vb,
	tmu_square_if.source sq
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH_A,
		S_FETCH_C,
		S_FETCH_B,
		S_FETCH_D,
		S_HANDOFF,
		S_NEXT
	} state_e;

	state_e state;
	state_e next_state;

	corner_e fetch_target;
	logic fetch_strobe;
	logic fetch_done;
	logic shift_points;
	logic is_y;
	coord_t rd_coord;
	square_t corners_q;

	logic move_reset;
	logic move_right;
	logic move_startline;
	logic move_down;
	logic move_up;
	pair_adr_t wk_pair_adr;
	pix_t wk_drx;
	pix_t wk_dry;
	logic last_col;
	logic last_row;

	tmu_mesh_walker i_walker (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.move_reset_i(move_reset),
		.move_right_i(move_right),
		.move_startline_i(move_startline),
		.move_down_i(move_down),
		.move_up_i(move_up),
		.vertex_adr_i(vertex_adr_i),
		.hlast_i(vertex_hlast_i),
		.vlast_i(vertex_vlast_i),
		.hoffset_i(dst_hoffset_i),
		.voffset_i(dst_voffset_i),
		.squarew_i(dst_squarew_i),
		.squareh_i(dst_squareh_i),
		.pair_adr_o(wk_pair_adr),
		.drx_o(wk_drx),
		.dry_o(wk_dry),
		.last_col_o(last_col),
		.last_row_o(last_row)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read engine.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// x word at the even address, y word right after it.
	assign vb.adr = {wk_pair_adr, is_y, 2'b00};
	assign vb.cti = CLASSIC;
	assign vb.cyc = vb.stb;
	assign rd_coord = vb.dat_r[COORD_W-1:0];

	function automatic point_t put_word(point_t p, logic y_word, coord_t v);
		point_t r;
		r = p;
		if (y_word)
			r.y = v;
		else
			r.x = v;
		return r;
	endfunction

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			vb.stb <= 1'b0;
			fetch_done <= 1'b0;
			is_y <= 1'b0;
		end else begin
			vb.stb <= 1'b0;
			fetch_done <= 1'b0;
			if (fetch_strobe && !fetch_done) begin
				vb.stb <= 1'b1;
				if (vb.ack) begin
					is_y <= ~is_y;
					if (is_y) begin
						fetch_done <= 1'b1;
						vb.stb <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (vb.ack) begin
			case (fetch_target)
				CORNER_A: corners_q.a <= put_word(corners_q.a, is_y, rd_coord);
				CORNER_B: corners_q.b <= put_word(corners_q.b, is_y, rd_coord);
				CORNER_C: corners_q.c <= put_word(corners_q.c, is_y, rd_coord);
				CORNER_D: corners_q.d <= put_word(corners_q.d, is_y, rd_coord);
			endcase
		end
		if (shift_points) begin
			corners_q.a <= corners_q.b;
			corners_q.c <= corners_q.d;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// controller.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		fetch_target = CORNER_A;
		fetch_strobe = 1'b0;
		shift_points = 1'b0;
		move_reset = 1'b0;
		move_right = 1'b0;
		move_startline = 1'b0;
		move_down = 1'b0;
		move_up = 1'b0;
		busy_o = 1'b1;
		case (state)
			S_IDLE: begin
				busy_o = 1'b0;
				move_reset = 1'b1;
				if (start_i)
					next_state = S_FETCH_A;
			end
			S_FETCH_A: begin
				fetch_strobe = 1'b1;
				if (fetch_done) begin
					move_down = 1'b1;
					next_state = S_FETCH_C;
				end
			end
			S_FETCH_C: begin
				fetch_target = CORNER_C;
				fetch_strobe = 1'b1;
				if (fetch_done) begin
					move_right = 1'b1;
					move_up = 1'b1;
					next_state = S_FETCH_B;
				end
			end
			S_FETCH_B: begin
				fetch_target = CORNER_B;
				fetch_strobe = 1'b1;
				if (fetch_done) begin
					move_down = 1'b1;
					next_state = S_FETCH_D;
				end
			end
			S_FETCH_D: begin
				fetch_target = CORNER_D;
				fetch_strobe = 1'b1;
				if (fetch_done)
					next_state = S_HANDOFF;
			end
			S_HANDOFF: begin
				if (sq.ack)
					next_state = S_NEXT;
			end
			S_NEXT: begin
				// walker sits on corner D here.
				if (!last_col) begin
					move_right = 1'b1;
					move_up = 1'b1;
					shift_points = 1'b1;
					next_state = S_FETCH_B;
				end else if (last_row) begin
					next_state = S_IDLE;
				end else begin
					move_startline = 1'b1;
					next_state = S_FETCH_A;
				end
			end
			default: next_state = S_IDLE;
		endcase
	end

	// during hand-off the walker is one square right and down of A.
	assign sq.stb = (state == S_HANDOFF);
	assign sq.corners = corners_q;
	assign sq.drx = wk_drx - pix_t'({1'b0, dst_squarew_i});
	assign sq.dry = wk_dry - pix_t'({1'b0, dst_squareh_i});

	a_bus_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(vb.stb && !vb.ack) |=> (vb.cyc && vb.stb && $stable(vb.adr)));

	// square stays offered, unchanged, until setup takes it.
	a_handoff_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(sq.stb && !sq.ack) |=> (sq.stb && $stable(sq.corners)));

endmodule

`default_nettype wire

//--- source/tmu_mesh_walker.sv
// mesh position tracker for the vertex fetch block.
// steps column and row on single-cycle commands, follows the destination
// pixel along and gives the pair index of the current mesh point.
`timescale 1ns/1ps
`default_nettype none

module tmu_mesh_walker import tmu_geom_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic move_reset_i,
	input logic move_right_i,
	input logic move_startline_i,
	input logic move_down_i,
	input logic move_up_i,
	input pair_adr_t vertex_adr_i,
	input mesh_idx_t hlast_i,
	input mesh_idx_t vlast_i,
	input pix_t hoffset_i,
	input pix_t voffset_i,
	input sqsize_t squarew_i,
	input sqsize_t squareh_i,
	output pair_adr_t pair_adr_o,
	output pix_t drx_o,
	output pix_t dry_o,
	output logic last_col_o,
	output logic last_row_o
);

	mesh_idx_t col_q;
	mesh_idx_t row_q;

	always_ff @(posedge sys_clk) begin
		if (sys_rst || move_reset_i) begin
			col_q <= '0;
			row_q <= '0;
			drx_o <= hoffset_i;
			dry_o <= voffset_i;
		end else begin
			if (move_right_i) begin
				col_q <= col_q + 7'd1;
				drx_o <= drx_o + pix_t'({1'b0, squarew_i});
			end else if (move_startline_i) begin
				col_q <= '0;
				drx_o <= hoffset_i;
			end
			if (move_down_i) begin
				row_q <= row_q + 7'd1;
				dry_o <= dry_o + pix_t'({1'b0, squareh_i});
			end else if (move_up_i) begin
				row_q <= row_q - 7'd1;
				dry_o <= dry_o - pix_t'({1'b0, squareh_i});
			end
		end
	end

	// mesh rows are 128 points apart.
	assign pair_adr_o = vertex_adr_i + pair_adr_t'({row_q, col_q});
	assign last_col_o = (col_q == hlast_i);
	assign last_row_o = (row_q == vlast_i);

	// the fetch order only steps up from a lower corner.
	a_no_up_from_top: assert property (@(posedge sys_clk) disable iff (sys_rst)
		move_up_i |-> (row_q != '0));

endmodule

`default_nettype wire

//--- source/tmu_ifaces.sv
// interfaces inside the vertex front end.
// tmu_vb_if carries single-beat reads from fetch to the vertex memory,
// tmu_square_if hands a fetched square from fetch to setup.
`timescale 1ns/1ps
`default_nettype none

interface tmu_vb_if import tmu_bus_pkg::*; ();

	logic [BUS_AW-1:0] adr;
	cti_e cti;
	logic cyc;
	logic stb;
	logic ack;
	logic [BUS_DW-1:0] dat_r;

	// master holds stb until ack, slave acks one cycle later.
	modport master (output adr, cti, cyc, stb, input ack, dat_r);
	modport slave (input adr, cti, cyc, stb, output ack, dat_r);

endinterface

interface tmu_square_if import tmu_geom_pkg::*; ();

	logic stb;
	logic ack;
	square_t corners;

	// upper-left destination pixel of the square.
	pix_t drx;
	pix_t dry;

	// transfer on stb and ack both high.
	modport source (output stb, corners, drx, dry, input ack);
	modport sink (input stb, corners, drx, dry, output ack);

endinterface

`default_nettype wire

//--- source/tmu_bus_pkg.sv
// vertex bus widths and cycle types.
// used by the bus interface, the fetch engine and the vertex memory.
`default_nettype none

package tmu_bus_pkg;

	localparam int BUS_AW = 32;
	localparam int BUS_DW = 32;

	// only single-beat cycles are issued.
	typedef enum logic [2:0] {
		CLASSIC = 3'b000,
		END = 3'b111
	} cti_e;

endpackage

`default_nettype wire

//--- source/tmu_geom_pkg.sv
// texture coordinate, destination pixel and mesh types.
// shared by the fetch block, the square setup stage and the top level.
`default_nettype none

package tmu_geom_pkg;

	// texture coordinates keep 18 significant bits, signed.
	localparam int COORD_W = 18;

	typedef logic signed [COORD_W-1:0] coord_t;
	typedef logic signed [11:0] pix_t;
	typedef logic [10:0] sqsize_t;
	typedef logic [6:0] mesh_idx_t;
	typedef logic [28:0] pair_adr_t;

	// corner register selected by a vertex fetch.
	typedef enum logic [1:0] {
		CORNER_A,
		CORNER_B,
		CORNER_C,
		CORNER_D
	} corner_e;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// A B on top, C D below.
	typedef struct packed {
		point_t a;
		point_t b;
		point_t c;
		point_t d;
	} square_t;

endpackage

`default_nettype wire
